// ==== common/bpu_pkg.sv ====
package bpu_pkg;

    localparam int BHT_IDX_W = 10;
    localparam int BHT_TAG_W = 8;
    localparam int BHT_ENTRY = 1 << BHT_IDX_W;

    typedef logic [31:0]          addr_t;
    typedef logic [BHT_IDX_W-1:0] bht_idx_t;
    typedef logic [BHT_TAG_W-1:0] bht_tag_t;
    typedef logic [1:0]           ctr_t;

    localparam ctr_t  CTR_INIT    = 2'b10;             // weakly taken
    localparam addr_t INST_BYTES  = 32'd4;
    localparam addr_t FETCH_BYTES = 32'd8;             // one dual-issue pair
    localparam addr_t RESET_PC    = 32'h0000_1000;

    // folded upper bits, word offset in the low nibble
    function automatic bht_idx_t bht_index(input addr_t a);
        bht_index = {a[29:24] ^ a[23:18] ^ a[17:12] ^ a[11:6], a[5:2]};
    endfunction

    function automatic bht_tag_t bht_tag(input addr_t a);
        bht_tag = a[31:24];
    endfunction

    function automatic ctr_t ctr_inc(input ctr_t c);
        if (c == 2'b11)
        begin
            ctr_inc = c;                               // saturate high
        end
        else
        begin
            ctr_inc = c + 2'b01;
        end
    endfunction

    function automatic ctr_t ctr_dec(input ctr_t c);
        if (c == 2'b00)
        begin
            ctr_dec = c;                               // saturate low
        end
        else
        begin
            ctr_dec = c - 2'b01;
        end
    endfunction

endpackage

// ==== src/fetch_pc.sv ====
`timescale 1ns/10ps

module fetch_pc import bpu_pkg::*;
(
    input  logic  cpu_clk,
    input  logic  cpu_rstn,
    input  logic  fetch_en,
    input  addr_t pred_addr,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    output addr_t if_pc,
    output logic  if_valid
);

    addr_t next_pc;

    // redirect from EX overrides the predictor
    always_comb
    begin
        if (redirect_valid)
        begin
            next_pc = redirect_pc;
        end
        else if (fetch_en)
        begin
            next_pc = pred_addr;
        end
        else
        begin
            next_pc = if_pc;                           // stalled, hold
        end
    end

    always_ff @(posedge cpu_clk or negedge cpu_rstn)
    begin
        if (!cpu_rstn)
        begin
            if_pc <= RESET_PC;
        end
        else
        begin
            if_pc <= next_pc;
        end
    end

    assign if_valid = fetch_en;

    // targets come from the tables and from EX, both must keep word alignment
    a_pc_aligned: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        if_pc[1:0] == 2'b00);

endmodule

// ==== bpu/bht_btb.sv ====
`timescale 1ns/10ps

module bht_btb import bpu_pkg::*;
(
    input  logic  cpu_clk,
    input  logic  cpu_rstn,
    input  addr_t if_pc,
    input  logic  if_valid,
    input  addr_t ex_pc,
    input  logic  live1,
    input  logic  live2,
    input  logic  ex_is_bj1,
    input  logic  ex_is_bj2,
    input  logic  real_taken1,
    input  logic  real_taken2,
    input  addr_t real_addr1,
    input  addr_t real_addr2,
    output logic  pred_taken1,
    output logic  pred_taken2,
    output addr_t pred_addr,
    output addr_t pred_tgt1,
    output addr_t pred_tgt2
);

    logic [BHT_ENTRY-1:0] valid;
    bht_tag_t             tag_mem [BHT_ENTRY];
    ctr_t                 ctr_mem [BHT_ENTRY];
    addr_t                tgt_mem [BHT_ENTRY];

    addr_t    if_pc4;
    bht_idx_t if_idx1;
    bht_idx_t if_idx2;

    // per-slot EX view, slot 0 is ex_pc and slot 1 is ex_pc+4
    addr_t    ex_addr    [2];
    bht_idx_t ex_idx     [2];
    bht_tag_t ex_tag     [2];
    logic     slot_live  [2];
    logic     slot_bj    [2];
    logic     slot_taken [2];
    addr_t    slot_real  [2];

    logic     entry_vld  [2];
    logic     entry_hit  [2];
    logic     do_alloc   [2];
    logic     do_upd     [2];
    logic     do_repl    [2];
    logic     wr_en      [2];
    logic     wr_tgt_en  [2];
    ctr_t     wr_ctr     [2];

    assign if_pc4  = if_pc + INST_BYTES;
    assign if_idx1 = bht_index(if_pc);
    assign if_idx2 = bht_index(if_pc4);

    assign pred_taken1 = if_valid && valid[if_idx1] && (tag_mem[if_idx1] == bht_tag(if_pc))
                         && ctr_mem[if_idx1][1];
    assign pred_taken2 = if_valid && valid[if_idx2] && (tag_mem[if_idx2] == bht_tag(if_pc4))
                         && ctr_mem[if_idx2][1];
    assign pred_tgt1   = tgt_mem[if_idx1];
    assign pred_tgt2   = tgt_mem[if_idx2];
    assign pred_addr   = pred_taken1 ? pred_tgt1 :
                         pred_taken2 ? pred_tgt2 : if_pc + FETCH_BYTES;

    assign ex_addr[0]    = ex_pc;
    assign ex_addr[1]    = ex_pc + INST_BYTES;
    assign slot_live[0]  = live1;
    assign slot_live[1]  = live2;
    assign slot_bj[0]    = ex_is_bj1;
    assign slot_bj[1]    = ex_is_bj2;
    assign slot_taken[0] = real_taken1;
    assign slot_taken[1] = real_taken2;
    assign slot_real[0]  = real_addr1;
    assign slot_real[1]  = real_addr2;

    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            ex_idx[s]    = bht_index(ex_addr[s]);
            ex_tag[s]    = bht_tag(ex_addr[s]);
            entry_vld[s] = valid[ex_idx[s]];
            entry_hit[s] = entry_vld[s] && (tag_mem[ex_idx[s]] == ex_tag[s]);
            do_alloc[s]  = slot_live[s] && !entry_vld[s] && slot_taken[s];
            do_upd[s]    = slot_live[s] && entry_hit[s] && slot_bj[s];
            do_repl[s]   = slot_live[s] && entry_vld[s] && !entry_hit[s] && slot_taken[s];
            wr_en[s]     = do_alloc[s] || do_upd[s] || do_repl[s];
            wr_tgt_en[s] = do_alloc[s] || do_repl[s] || (do_upd[s] && slot_taken[s]);
            if (do_upd[s])
            begin
                wr_ctr[s] = slot_taken[s] ? ctr_inc(ctr_mem[ex_idx[s]])
                                          : ctr_dec(ctr_mem[ex_idx[s]]);
            end
            else
            begin
                wr_ctr[s] = CTR_INIT;                  // fresh or replaced entry
            end
        end
    end

    always_ff @(posedge cpu_clk or negedge cpu_rstn)
    begin
        if (!cpu_rstn)
        begin
            valid <= '0;
            for (int i = 0; i < BHT_ENTRY; i++)
            begin
                ctr_mem[i] <= CTR_INIT;
            end
        end
        else
        begin
            for (int s = 0; s < 2; s++)
            begin
                if (wr_en[s])
                begin
                    valid[ex_idx[s]]   <= 1'b1;
                    ctr_mem[ex_idx[s]] <= wr_ctr[s];
                end
            end
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        for (int s = 0; s < 2; s++)
        begin
            if (wr_en[s])
            begin
                tag_mem[ex_idx[s]] <= ex_tag[s];
            end
            if (wr_tgt_en[s])
            begin
                tgt_mem[ex_idx[s]] <= slot_real[s];
            end
        end
    end

    // the two slots of a pair differ in the word offset bits of the index
    a_no_dual_write: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        !(wr_en[0] && wr_en[1] && (ex_idx[0] == ex_idx[1])));

endmodule

// ==== src/if_ex_pipe.sv ====
`timescale 1ns/10ps

module if_ex_pipe import bpu_pkg::*;
(
    input  logic  cpu_clk,
    input  logic  cpu_rstn,
    input  addr_t if_pc,
    input  logic  if_valid,
    input  logic  pred_taken1,
    input  logic  pred_taken2,
    input  logic  flush,
    input  addr_t pred_tgt1,
    input  addr_t pred_tgt2,
    output addr_t ex_pc,
    output logic  ex_valid1,
    output logic  ex_valid2,
    output logic  ex_pred_taken1,
    output logic  ex_pred_taken2,
    output addr_t ex_pred_tgt1,
    output addr_t ex_pred_tgt2
);

    logic load;

    assign load = if_valid && !flush;                  // otherwise a bubble

    always_ff @(posedge cpu_clk or negedge cpu_rstn)
    begin
        if (!cpu_rstn)
        begin
            ex_valid1      <= 1'b0;
            ex_valid2      <= 1'b0;
            ex_pred_taken1 <= 1'b0;
            ex_pred_taken2 <= 1'b0;
        end
        else
        begin
            ex_valid1      <= load;
            ex_valid2      <= load && !pred_taken1;    // shadow of a taken slot 1
            ex_pred_taken1 <= load && pred_taken1;
            ex_pred_taken2 <= load && !pred_taken1 && pred_taken2;
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        if (load)
        begin
            ex_pc        <= if_pc;
            ex_pred_tgt1 <= pred_tgt1;
            ex_pred_tgt2 <= pred_tgt2;
        end
    end

endmodule

// ==== src/branch_resolve.sv ====
`timescale 1ns/10ps

module branch_resolve import bpu_pkg::*;
(
    input  addr_t ex_pc,
    input  logic  ex_valid1,
    input  logic  ex_valid2,
    input  logic  ex_pred_taken1,
    input  logic  ex_pred_taken2,
    input  addr_t ex_pred_tgt1,
    input  addr_t ex_pred_tgt2,
    input  logic  ex_is_bj1,
    input  logic  ex_is_bj2,
    input  logic  real_taken1,
    input  logic  real_taken2,
    input  addr_t real_addr1,
    input  addr_t real_addr2,
    output logic  pred_error1,
    output logic  pred_error2,
    output logic  live1,
    output logic  live2,
    output logic  redirect_valid,
    output addr_t redirect_pc
);

    addr_t ex_pc4;
    logic  miss1;
    logic  miss2;

    // wrong direction, or right direction with a stale target
    function automatic logic slot_miss(input logic  pred_taken,
                                       input logic  is_bj,
                                       input logic  real_taken,
                                       input addr_t pred_tgt,
                                       input addr_t real_addr);
        slot_miss = (pred_taken != real_taken)
                    || (is_bj && pred_taken && real_taken && (pred_tgt != real_addr));
    endfunction

    assign ex_pc4 = ex_pc + INST_BYTES;

    assign miss1 = slot_miss(ex_pred_taken1, ex_is_bj1, real_taken1, ex_pred_tgt1, real_addr1);
    assign miss2 = slot_miss(ex_pred_taken2, ex_is_bj2, real_taken2, ex_pred_tgt2, real_addr2);

    assign pred_error1    = ex_valid1 && miss1;
    assign pred_error2    = ex_valid2 && !pred_error1 && miss2;   // older slot first
    assign redirect_valid = pred_error1 || pred_error2;

    assign live1 = ex_valid1;
    assign live2 = ex_valid2 && !pred_error1;

    always_comb
    begin
        if (pred_error1)
        begin
            redirect_pc = real_taken1 ? real_addr1 : ex_pc4;
        end
        else if (pred_error2)
        begin
            redirect_pc = real_taken2 ? real_addr2 : ex_pc + FETCH_BYTES;
        end
        else
        begin
            redirect_pc = ex_pc + FETCH_BYTES;         // unused without an error
        end
    end

endmodule

// ==== src/bpu_top.sv ====
`timescale 1ns/10ps

module bpu_top import bpu_pkg::*;
(
    input  logic  cpu_clk,
    input  logic  cpu_rstn,
    input  logic  fetch_en,
    input  logic  ex_is_bj1,
    input  logic  ex_is_bj2,
    input  logic  real_taken1,
    input  logic  real_taken2,
    input  addr_t real_addr1,
    input  addr_t real_addr2,
    output addr_t if_pc,
    output addr_t ex_pc,
    output logic  ex_valid1,
    output logic  ex_valid2,
    output logic  ex_pred_taken1,
    output logic  ex_pred_taken2,
    output logic  pred_error1,
    output logic  pred_error2,
    output logic  redirect_valid
);

    logic  if_valid;
    logic  pred_taken1;
    logic  pred_taken2;
    addr_t pred_addr;
    addr_t pred_tgt1;
    addr_t pred_tgt2;
    addr_t ex_pred_tgt1;
    addr_t ex_pred_tgt2;
    logic  live1;
    logic  live2;
    addr_t redirect_pc;

    fetch_pc u_fetch_pc
    (
        .cpu_clk        (cpu_clk),
        .cpu_rstn       (cpu_rstn),
        .fetch_en       (fetch_en),
        .pred_addr      (pred_addr),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .if_pc          (if_pc),
        .if_valid       (if_valid)
    );

    bht_btb u_bht_btb
    (
        .cpu_clk     (cpu_clk),
        .cpu_rstn    (cpu_rstn),
        .if_pc       (if_pc),
        .if_valid    (if_valid),
        .ex_pc       (ex_pc),
        .live1       (live1),
        .live2       (live2),
        .ex_is_bj1   (ex_is_bj1),
        .ex_is_bj2   (ex_is_bj2),
        .real_taken1 (real_taken1),
        .real_taken2 (real_taken2),
        .real_addr1  (real_addr1),
        .real_addr2  (real_addr2),
        .pred_taken1 (pred_taken1),
        .pred_taken2 (pred_taken2),
        .pred_addr   (pred_addr),
        .pred_tgt1   (pred_tgt1),
        .pred_tgt2   (pred_tgt2)
    );

    if_ex_pipe u_if_ex_pipe
    (
        .cpu_clk        (cpu_clk),
        .cpu_rstn       (cpu_rstn),
        .if_pc          (if_pc),
        .if_valid       (if_valid),
        .pred_taken1    (pred_taken1),
        .pred_taken2    (pred_taken2),
        .flush          (redirect_valid),              // squash on mispredict
        .pred_tgt1      (pred_tgt1),
        .pred_tgt2      (pred_tgt2),
        .ex_pc          (ex_pc),
        .ex_valid1      (ex_valid1),
        .ex_valid2      (ex_valid2),
        .ex_pred_taken1 (ex_pred_taken1),
        .ex_pred_taken2 (ex_pred_taken2),
        .ex_pred_tgt1   (ex_pred_tgt1),
        .ex_pred_tgt2   (ex_pred_tgt2)
    );

    branch_resolve u_branch_resolve
    (
        .ex_pc          (ex_pc),
        .ex_valid1      (ex_valid1),
        .ex_valid2      (ex_valid2),
        .ex_pred_taken1 (ex_pred_taken1),
        .ex_pred_taken2 (ex_pred_taken2),
        .ex_pred_tgt1   (ex_pred_tgt1),
        .ex_pred_tgt2   (ex_pred_tgt2),
        .ex_is_bj1      (ex_is_bj1),
        .ex_is_bj2      (ex_is_bj2),
        .real_taken1    (real_taken1),
        .real_taken2    (real_taken2),
        .real_addr1     (real_addr1),
        .real_addr2     (real_addr2),
        .pred_error1    (pred_error1),
        .pred_error2    (pred_error2),
        .live1          (live1),
        .live2          (live2),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== test/bpu_model.svh ====
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

localparam addr_t REGION_A = 32'h0000_1000;
localparam addr_t REGION_B = 32'h0104_1000;        // folds onto region a's indices, tag 01

// mirror of the tables
logic     m_valid [BHT_ENTRY];
bht_tag_t m_tag   [BHT_ENTRY];
ctr_t     m_ctr   [BHT_ENTRY];
addr_t    m_tgt   [BHT_ENTRY];

// mirror of fetch and the EX register
addr_t m_if_pc;
addr_t m_ex_pc;
addr_t m_ex_tgt1;
addr_t m_ex_tgt2;
logic  m_ex_v1;
logic  m_ex_v2;
logic  m_ex_pt1;
logic  m_ex_pt2;
logic  exp_err1;
logic  exp_err2;
addr_t exp_redir_pc;

function automatic bht_idx_t fold_index(input addr_t a);
    logic [5:0] hi;
    hi = a[29:24] ^ a[23:18] ^ a[17:12] ^ a[11:6];
    return {hi, a[5:2]};
endfunction

function automatic logic [31:0] scramble(input addr_t a);
    logic [31:0] h;
    h = {2'b00, a[31:2]} * 32'h9E37_79B1;
    return h ^ (h >> 15);
endfunction

function automatic logic is_branch_at(input addr_t a);
    logic [31:0] h;
    h = scramble(a);
    return (h[9:0] % 10'd3) == 10'd0;                // roughly one slot in three
endfunction

// alt picks the second destination of an indirect jump
function automatic addr_t target_of(input addr_t a, input logic alt);
    logic [31:0] h;
    addr_t       off;
    h   = scramble(a);
    off = {24'd0, h[29:24] ^ {alt, 5'd0}, 2'b00};
    return (h[12] ? REGION_B : REGION_A) + off;
endfunction

task automatic pick_outcome(input logic valid, input addr_t a, output logic bj,
                            output logic taken, output addr_t dest);
    logic [31:0] h;
    logic [7:0]  r;
    logic        indirect;
    h        = scramble(a);
    indirect = (h[20:18] == 3'b000);
    bj       = is_branch_at(a);
    taken    = 1'b0;
    dest     = a + INST_BYTES;
    r        = '0;
    if (valid && bj)
    begin
        take_bits(1, r);
        taken = r[0];
    end
    if (taken)
    begin
        if (indirect)
        begin
            take_bits(1, r);
        end
        dest = target_of(a, indirect && r[0]);
    end
endtask

function automatic logic predicts_taken(input addr_t a);
    bht_idx_t i;
    i = fold_index(a);
    return m_valid[i] && (m_tag[i] == a[31:24]) && m_ctr[i][1];
endfunction

task automatic reset_model();
    for (int i = 0; i < BHT_ENTRY; i++)
    begin
        m_valid[i] = 1'b0;
        m_tag[i]   = '0;
        m_ctr[i]   = CTR_INIT;
        m_tgt[i]   = '0;
    end
    m_if_pc   = RESET_PC;
    m_ex_pc   = '0;
    m_ex_tgt1 = '0;
    m_ex_tgt2 = '0;
    m_ex_v1   = 1'b0;
    m_ex_v2   = 1'b0;
    m_ex_pt1  = 1'b0;
    m_ex_pt2  = 1'b0;
endtask

task automatic train_entry(input addr_t a, input logic bj, input logic taken,
                           input addr_t dest);
    bht_idx_t i;
    logic     hit;
    i   = fold_index(a);
    hit = m_valid[i] && (m_tag[i] == a[31:24]);
    if (hit && bj)
    begin
        if (taken)
        begin
            m_ctr[i] = (m_ctr[i] == 2'b11) ? 2'b11 : m_ctr[i] + 2'b01;
            m_tgt[i] = dest;
        end
        else
        begin
            m_ctr[i] = (m_ctr[i] == 2'b00) ? 2'b00 : m_ctr[i] - 2'b01;
        end
    end
    else if (taken && !hit)
    begin
        m_valid[i] = 1'b1;                            // allocate or replace
        m_tag[i]   = a[31:24];
        m_tgt[i]   = dest;
        m_ctr[i]   = CTR_INIT;
    end
endtask

// EX comparison for the current outcome inputs
task automatic resolve_ex();
    logic miss1;
    logic miss2;
    miss1 = (m_ex_pt1 != real_taken1) || (real_taken1 && m_ex_pt1 && (m_ex_tgt1 != real_addr1));
    miss2 = (m_ex_pt2 != real_taken2) || (real_taken2 && m_ex_pt2 && (m_ex_tgt2 != real_addr2));
    exp_err1 = m_ex_v1 && miss1;
    exp_err2 = m_ex_v2 && !exp_err1 && miss2;
    if (exp_err1)
    begin
        exp_redir_pc = real_taken1 ? real_addr1 : m_ex_pc + 32'd4;
    end
    else
    begin
        exp_redir_pc = real_taken2 ? real_addr2 : m_ex_pc + 32'd8;
    end
endtask

// one rising edge: lookup on the old tables, then train, pipe, fetch
task automatic advance_model();
    addr_t pc4;
    addr_t tgt1;
    addr_t tgt2;
    logic  pt1;
    logic  pt2;
    logic  redir;
    logic  load;
    pc4   = m_if_pc + INST_BYTES;
    pt1   = fetch_en && predicts_taken(m_if_pc);
    pt2   = fetch_en && predicts_taken(pc4);
    tgt1  = m_tgt[fold_index(m_if_pc)];
    tgt2  = m_tgt[fold_index(pc4)];
    redir = exp_err1 || exp_err2;
    load  = fetch_en && !redir;
    if (m_ex_v1)
    begin
        train_entry(m_ex_pc, ex_is_bj1, real_taken1, real_addr1);
    end
    if (m_ex_v2 && !exp_err1)
    begin
        train_entry(m_ex_pc + INST_BYTES, ex_is_bj2, real_taken2, real_addr2);
    end
    if (load)
    begin
        m_ex_pc   = m_if_pc;
        m_ex_tgt1 = tgt1;
        m_ex_tgt2 = tgt2;
    end
    m_ex_v1  = load;
    m_ex_v2  = load && !pt1;                          // squashed behind taken slot 1
    m_ex_pt1 = load && pt1;
    m_ex_pt2 = load && !pt1 && pt2;
    if (redir)
    begin
        m_if_pc = exp_redir_pc;
    end
    else if (fetch_en)
    begin
        m_if_pc = pt1 ? tgt1 : (pt2 ? tgt2 : m_if_pc + FETCH_BYTES);
    end
endtask

`endif

// ==== test/tb_bpu.sv ====
`timescale 1ns/10ps

module tb_bpu import bpu_pkg::*;
();

    localparam int RESET_CYCLES   = 16;
    localparam int RUN_CYCLES     = 4000;
    localparam int TIMEOUT_CYCLES = 4200;          // reset and run plus margin

    logic  cpu_clk;
    logic  cpu_rstn;
    logic  fetch_en;
    logic  ex_is_bj1;
    logic  ex_is_bj2;
    logic  real_taken1;
    logic  real_taken2;
    addr_t real_addr1;
    addr_t real_addr2;
    addr_t if_pc;
    addr_t ex_pc;
    logic  ex_valid1;
    logic  ex_valid2;
    logic  ex_pred_taken1;
    logic  ex_pred_taken2;
    logic  pred_error1;
    logic  pred_error2;
    logic  redirect_valid;

    logic [15:0] lfsr_state;
    string       test_name;
    int          cycle_count = 0;
    int          error_count = 0;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    `include "bpu_model.svh"

    bpu_top u_bpu_top
    (
        .cpu_clk        (cpu_clk),
        .cpu_rstn       (cpu_rstn),
        .fetch_en       (fetch_en),
        .ex_is_bj1      (ex_is_bj1),
        .ex_is_bj2      (ex_is_bj2),
        .real_taken1    (real_taken1),
        .real_taken2    (real_taken2),
        .real_addr1     (real_addr1),
        .real_addr2     (real_addr2),
        .if_pc          (if_pc),
        .ex_pc          (ex_pc),
        .ex_valid1      (ex_valid1),
        .ex_valid2      (ex_valid2),
        .ex_pred_taken1 (ex_pred_taken1),
        .ex_pred_taken2 (ex_pred_taken2),
        .pred_error1    (pred_error1),
        .pred_error2    (pred_error2),
        .redirect_valid (redirect_valid)
    );

    initial
    begin
        cpu_clk = 1'b0;
        forever
        begin
            #20 cpu_clk = ~cpu_clk;
        end
    end

    always @(posedge cpu_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Test failed");
            $fatal(1, "timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("** Error %s %s: expected %0b, actual %0b", test_name, name, expected, actual);
            $display("Test failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_word(input string name, input addr_t expected, input addr_t actual);
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("** Error %s %s: expected %h, actual %h", test_name, name, expected, actual);
            $display("Test failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic compare_outputs();
        check_word("if_pc", m_if_pc, if_pc);
        check_bit("ex_valid1", m_ex_v1, ex_valid1);
        check_bit("ex_valid2", m_ex_v2, ex_valid2);
        check_bit("ex_pred_taken1", m_ex_pt1, ex_pred_taken1);
        check_bit("ex_pred_taken2", m_ex_pt2, ex_pred_taken2);
        check_bit("pred_error1", exp_err1, pred_error1);
        check_bit("pred_error2", exp_err2, pred_error2);
        check_bit("redirect_valid", exp_err1 || exp_err2, redirect_valid);
        if (m_ex_v1)
        begin
            check_word("ex_pc", m_ex_pc, ex_pc);
        end
    endtask

    task automatic drive_inputs();
        logic [7:0] r;
        take_bits(3, r);
        fetch_en = (r[2:0] != 3'b000);             // idle about one cycle in eight
        pick_outcome(m_ex_v1, m_ex_pc, ex_is_bj1, real_taken1, real_addr1);
        pick_outcome(m_ex_v2, m_ex_pc + INST_BYTES, ex_is_bj2, real_taken2, real_addr2);
    endtask

    initial
    begin
        cpu_rstn    = 1'b0;
        fetch_en    = 1'b0;
        ex_is_bj1   = 1'b0;
        ex_is_bj2   = 1'b0;
        real_taken1 = 1'b0;
        real_taken2 = 1'b0;
        real_addr1  = '0;
        real_addr2  = '0;
        lfsr_state  = 16'd26;
        test_name   = "reset";
        reset_model();

        repeat (RESET_CYCLES)
        begin
            @(negedge cpu_clk);
            resolve_ex();
            compare_outputs();
        end
        cpu_rstn = 1'b1;
        advance_model();                            // first edge out of reset, fetch idle

        test_name = "random_program";
        for (int n = 0; n < RUN_CYCLES; n++)
        begin
            @(negedge cpu_clk);
            drive_inputs();
            #1;
            resolve_ex();
            compare_outputs();
            advance_model();
        end

        if (error_count == 0)
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            $display("Test failed");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

// ==== verilog.f ====
+incdir+test
common/bpu_pkg.sv
src/fetch_pc.sv
bpu/bht_btb.sv
src/if_ex_pipe.sv
src/branch_resolve.sv
src/bpu_top.sv
test/tb_bpu.sv

// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = tb_bpu
FILELIST = verilog.f
OBJDIR   = obj_dir

BIN     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard test/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
